// File: ip_packet_src.f
design/pkt_gen_pkg.sv
design/pkt_gen_regs.sv
design/pkt_gen_sequencer.sv
design/ip_header_build.sv
design/frame_serializer.sv
design/ip_packet_src.sv
testbench/ip_packet_checker.sv
testbench/tb_ip_packet_src.sv

// File: testbench/tb_ip_packet_src.sv
/* Testbench for the IPv4 packet generator
   Programs random counted and shaped runs with random stream back-pressure */

`timescale 1ns/1ns
`default_nettype none

module tb_ip_packet_src;

    localparam int shaped_window = 2000;  // Cycles of continuous sending
    localparam int poll_limit    = 3000;

    logic        clk_ifc_avmm;
    logic        rst_n;
    logic [4:0]  address;
    logic        write;
    logic [31:0] writedata;
    logic        read;
    logic [31:0] readdata;
    logic [7:0]  tdata;
    logic        tvalid;
    logic        tlast;
    logic        tready;
    int          error_count;
    integer      seed;
    int          run;
    logic        timed_out;  // A run never went idle

    ip_packet_src ip_packet_src_i (.*);

    ip_packet_checker ip_packet_checker_i (.*);

    always #4 clk_ifc_avmm = ~clk_ifc_avmm;

    // About 70% ready
    always @(posedge clk_ifc_avmm) begin
        tready <= ({$random(seed)} % 10) < 7;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bus tasks

    task automatic bus_write(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clk_ifc_avmm);
        address   <= addr;
        writedata <= data;
        write     <= 1'b1;
        @(posedge clk_ifc_avmm);
        write <= 1'b0;
    endtask

    task automatic bus_read(input logic [4:0] addr, output logic [31:0] data);
        @(posedge clk_ifc_avmm);
        address <= addr;
        read    <= 1'b1;
        @(posedge clk_ifc_avmm);
        read <= 1'b0;
        @(posedge clk_ifc_avmm);  // Fixed one-cycle read latency
        data = readdata;
    endtask

    task automatic wait_for_idle();
        int          polls;
        logic [31:0] status;
        polls = 0;
        bus_read(pkt_gen_pkg::addr_status, status);
        while (status[31] && polls < poll_limit) begin
            polls++;
            bus_read(pkt_gen_pkg::addr_status, status);
        end
        if (status[31]) begin
            $display("Timeout, run still busy after %0d status polls", poll_limit);
            timed_out = 1'b1;
        end
    endtask

    task automatic program_headers();
        bus_write(pkt_gen_pkg::addr_tos, {$random(seed)});
        bus_write(pkt_gen_pkg::addr_identification, {$random(seed)});
        bus_write(pkt_gen_pkg::addr_ttl_protocol, {$random(seed)});
        bus_write(pkt_gen_pkg::addr_src_ip, {$random(seed)});
        bus_write(pkt_gen_pkg::addr_dst_ip, {$random(seed)});
        bus_write(pkt_gen_pkg::addr_dst_mac_hi, {$random(seed)});
        bus_write(pkt_gen_pkg::addr_dst_mac_lo, {$random(seed)});
    endtask

    // Random values into every writable register and read all back
    task automatic exercise_registers();
        logic [31:0] data;
        for (int a = 0; a < 10; a++) begin
            data = {$random(seed)};
            if (a == 0) begin
                data[0] = 1'b0;  // No start
            end
            bus_write(5'(a), data);
        end
        for (int a = 0; a < 32; a++) begin
            if (a < 16 || a > 20) begin
                bus_read(5'(a), data);
            end
        end
    endtask

    task automatic read_run_status();
        logic [31:0] data;
        bus_read(pkt_gen_pkg::addr_remaining, data);
        bus_read(pkt_gen_pkg::addr_tx_cnt_hi, data);
        bus_read(pkt_gen_pkg::addr_tx_cnt_lo, data);
    endtask

    // Register checks, three counted runs and one shaped run
    task automatic run_sequence();
        exercise_registers();

        // Counted runs
        for (run = 0; run < 3; run++) begin
            program_headers();
            bus_write(pkt_gen_pkg::addr_num_packets, 32'd1 + {$random(seed)} % 6);
            bus_write(pkt_gen_pkg::addr_ctrl, 32'h1);
            wait_for_idle();
            if (timed_out) begin
                return;
            end
            read_run_status();
        end

        // Shaped continuous run below one byte per cycle
        program_headers();
        bus_write(pkt_gen_pkg::addr_shaper_dec, 32'h2000 + {$random(seed)} % 32'he000);
        bus_write(pkt_gen_pkg::addr_ctrl, 32'h3);
        repeat (shaped_window) @(posedge clk_ifc_avmm);
        bus_write(pkt_gen_pkg::addr_ctrl, 32'h0);
        wait_for_idle();
        if (timed_out) begin
            return;
        end
        read_run_status();

        exercise_registers();
    endtask

    initial begin
        seed         = 32'h2be7_6ded;
        timed_out    = 1'b0;
        clk_ifc_avmm = 1'b0;
        rst_n        = 1'b0;
        address      = '0;
        write        = 1'b0;
        writedata    = '0;
        read         = 1'b0;
        tready       = 1'b0;
        repeat (5) @(posedge clk_ifc_avmm);
        rst_n <= 1'b1;

        run_sequence();

        $display("Checks done with %0d errors", error_count);
        if (error_count == 0 && !timed_out) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/ip_packet_checker.sv
/* Checker for the IPv4 packet generator
   Mirrors the written configuration, predicts frames and register reads */

`timescale 1ns/1ns
`default_nettype none

module ip_packet_checker (
    input  wire logic        clk_ifc_avmm,
    input  wire logic        rst_n,
    input  wire logic [4:0]  address,
    input  wire logic        write,
    input  wire logic [31:0] writedata,
    input  wire logic        read,
    input  wire logic [31:0] readdata,
    input  wire logic [7:0]  tdata,
    input  wire logic        tvalid,
    input  wire logic        tlast,
    input  wire logic        tready,
    output int               error_count
);

    localparam int hdr_len = pkt_gen_pkg::eth_hdr_bytes + pkt_gen_pkg::ip_hdr_bytes;

    // Copy of the writable registers
    logic        cont_q;
    logic [31:0] num_packets_q;
    logic [30:0] shaper_dec_q;
    logic [7:0]  tos_q;
    logic [15:0] ident_q;
    logic [15:0] ttl_proto_q;
    logic [31:0] src_ip_q;
    logic [31:0] dst_ip_q;
    logic [47:0] dst_mac_q;

    // Run tracking
    logic        run_cont;
    logic [31:0] num_at_start;
    longint      cycle;
    longint      start_cycle;
    longint      window;
    longint      bound;
    int          frames_seen;
    int          byte_idx;
    logic        rd_pend;
    logic [4:0]  rd_addr;
    logic [31:0] rd_exp;
    logic        rd_check;
    logic        hold_pend;
    logic [7:0]  hold_data;
    logic        hold_last;
    logic [7:0]  exp_byte;

    initial error_count = 0;

    task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("FAILED %0t %s expected %h actual %h", $time, name, exp, act);
        error_count++;
    endtask

    task automatic complain(input string what);
        $display("%0t %s", $time, what);
        error_count++;
    endtask

    // Ones' complement sum of the ten header words, checksum word as zero
    function automatic logic [15:0] ip_checksum();
        logic [31:0] acc;
        acc = {16'b0, pkt_gen_pkg::ip_version_ihl, tos_q} + pkt_gen_pkg::ip_total_length
            + ident_q + {pkt_gen_pkg::ip_flags_df, 13'b0} + ttl_proto_q
            + src_ip_q[31:16] + src_ip_q[15:0] + dst_ip_q[31:16] + dst_ip_q[15:0];
        while (acc[31:16] != 16'd0) begin
            acc = acc[15:0] + acc[31:16];
        end
        return ~acc[15:0];
    endfunction

    function automatic logic [7:0] expected_byte(input int idx, input logic [31:0] id);
        logic [8*hdr_len-1:0] hdr;
        int                   shift;
        hdr = {dst_mac_q, pkt_gen_pkg::mac_src, pkt_gen_pkg::eth_type_ipv4,
               pkt_gen_pkg::ip_version_ihl, tos_q, pkt_gen_pkg::ip_total_length,
               ident_q, pkt_gen_pkg::ip_flags_df, 13'b0, ttl_proto_q, ip_checksum(),
               src_ip_q, dst_ip_q};
        if (idx < hdr_len) begin
            return hdr[(hdr_len - 1 - idx) * 8 +: 8];
        end
        shift = 8 * (3 - (idx - hdr_len) % 4);  // Id word, MSB first
        return 8'(id >> shift);
    endfunction

    // Checks made when the sent counter is read after a run
    task automatic check_run_end();
        if (byte_idx != 0) begin
            complain($sformatf("Frame cut off after %0d bytes", byte_idx));
        end
        if (!run_cont && frames_seen != num_at_start) begin
            mismatch("frame count", num_at_start, frames_seen);
        end
        if (run_cont) begin
            bound = window * longint'(shaper_dec_q) / (pkt_gen_pkg::frame_bytes * 65536) + 2;
            if (frames_seen > bound) begin
                complain($sformatf("Shaped run sent %0d frames, limit is %0d", frames_seen, bound));
            end
            if (frames_seen == 0) begin
                complain("Shaped run sent no frames");
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus and stream monitor

    always @(posedge clk_ifc_avmm or negedge rst_n) begin
        if (!rst_n) begin
            {cont_q, num_packets_q, shaper_dec_q, tos_q, ident_q, ttl_proto_q} = '0;
            {src_ip_q, dst_ip_q, dst_mac_q} = '0;
            run_cont     = 1'b0;
            num_at_start = '0;
            cycle        = 0;
            start_cycle  = 0;
            window       = 0;
            frames_seen  = 0;
            byte_idx     = 0;
            rd_pend      = 1'b0;
            rd_addr      = '0;
            hold_pend    = 1'b0;
        end else begin
            cycle++;
            // Read data of the previous cycle
            if (rd_pend) begin
                rd_check = 1'b1;
                rd_exp   = '0;  // Unmapped
                case (rd_addr)
                    pkt_gen_pkg::addr_ctrl:           rd_exp = {30'b0, cont_q, 1'b0};
                    pkt_gen_pkg::addr_num_packets:    rd_exp = num_packets_q;
                    pkt_gen_pkg::addr_shaper_dec:     rd_exp = {1'b0, shaper_dec_q};
                    pkt_gen_pkg::addr_tos:            rd_exp = {24'b0, tos_q};
                    pkt_gen_pkg::addr_identification: rd_exp = {16'b0, ident_q};
                    pkt_gen_pkg::addr_ttl_protocol:   rd_exp = {16'b0, ttl_proto_q};
                    pkt_gen_pkg::addr_src_ip:         rd_exp = src_ip_q;
                    pkt_gen_pkg::addr_dst_ip:         rd_exp = dst_ip_q;
                    pkt_gen_pkg::addr_dst_mac_hi:     rd_exp = {16'b0, dst_mac_q[47:32]};
                    pkt_gen_pkg::addr_dst_mac_lo:     rd_exp = dst_mac_q[31:0];
                    pkt_gen_pkg::addr_status:         rd_check = 1'b0;
                    pkt_gen_pkg::addr_shaper_accum:   rd_check = 1'b0;
                    pkt_gen_pkg::addr_tx_cnt_lo:      rd_exp = frames_seen;
                    default: ;  // Remaining and counter high read zero after a run
                endcase
                if (rd_check && readdata !== rd_exp) begin
                    mismatch($sformatf("readdata[addr %0d]", rd_addr), rd_exp, readdata);
                end
                if (rd_addr == pkt_gen_pkg::addr_tx_cnt_lo) begin
                    check_run_end();
                end
            end
            rd_pend = read;
            rd_addr = address;

            if (write) begin
                case (address)
                    pkt_gen_pkg::addr_ctrl: begin
                        cont_q = writedata[1];
                        if (writedata[0]) begin
                            run_cont     = writedata[1];
                            num_at_start = num_packets_q;
                            start_cycle  = cycle;
                            window       = 0;
                            frames_seen  = 0;
                        end else if (!writedata[1] && run_cont && window == 0) begin
                            window = cycle - start_cycle;  // End of shaped window
                        end
                    end
                    pkt_gen_pkg::addr_num_packets:    num_packets_q = writedata;
                    pkt_gen_pkg::addr_shaper_dec:     shaper_dec_q = writedata[30:0];
                    pkt_gen_pkg::addr_tos:            tos_q = writedata[7:0];
                    pkt_gen_pkg::addr_identification: ident_q = writedata[15:0];
                    pkt_gen_pkg::addr_ttl_protocol:   ttl_proto_q = writedata[15:0];
                    pkt_gen_pkg::addr_src_ip:         src_ip_q = writedata;
                    pkt_gen_pkg::addr_dst_ip:         dst_ip_q = writedata;
                    pkt_gen_pkg::addr_dst_mac_hi:     dst_mac_q[47:32] = writedata[15:0];
                    pkt_gen_pkg::addr_dst_mac_lo:     dst_mac_q[31:0] = writedata;
                    default: ;
                endcase
            end

            // Stalled beat must hold
            if (hold_pend && (!tvalid || tdata !== hold_data || tlast !== hold_last)) begin
                complain("Stream output changed while tready was low");
            end
            hold_pend = tvalid && !tready;
            hold_data = tdata;
            hold_last = tlast;

            if (tvalid && tready) begin
                exp_byte = expected_byte(byte_idx, frames_seen + 1);
                if (tdata !== exp_byte) begin
                    mismatch($sformatf("tdata[frame %0d byte %0d]", frames_seen + 1, byte_idx),
                             exp_byte, tdata);
                end
                if (tlast !== (byte_idx == pkt_gen_pkg::frame_bytes - 1)) begin
                    mismatch($sformatf("tlast[byte %0d]", byte_idx),
                             byte_idx == pkt_gen_pkg::frame_bytes - 1, tlast);
                end
                if (tlast || byte_idx == pkt_gen_pkg::frame_bytes - 1) begin
                    frames_seen++;
                    byte_idx = 0;
                end else begin
                    byte_idx++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/ip_packet_src.sv
/* IPv4 packet generator top level
   Register bank, sequencer, header builder and serializer on one clock */

`timescale 1ns/1ns
`default_nettype none

module ip_packet_src (
    input  wire logic        clk_ifc_avmm,
    input  wire logic        rst_n,
    input  wire logic [4:0]  address,
    input  wire logic        write,
    input  wire logic [31:0] writedata,
    input  wire logic        read,
    output logic      [31:0] readdata,
    output logic      [7:0]  tdata,
    output logic             tvalid,
    output logic             tlast,
    input  wire logic        tready
);

    // Configuration
    logic                       start;
    logic                       continuous;
    logic [31:0]                num_packets;
    pkt_gen_pkg::shaper_dec_t   shaper_dec;
    logic [7:0]                 tos;
    logic [15:0]                identification;
    logic [7:0]                 ttl;
    logic [7:0]                 protocol;
    logic [31:0]                src_ip;
    logic [31:0]                dst_ip;
    logic [47:0]                dst_mac;

    // Status
    pkt_gen_pkg::seq_state_t    state;
    logic [31:0]                remaining;
    pkt_gen_pkg::shaper_accum_t shaper_accum;
    logic [63:0]                tx_cnt;
    logic                       sending;

    // Pipeline handshakes
    logic                       req_valid;
    logic                       req_ready;
    logic [31:0]                req_id;
    logic                       hdr_valid;
    logic                       hdr_ready;
    logic [15:0]                hdr_checksum;
    logic [31:0]                hdr_id;
    logic                       frame_done;

    pkt_gen_regs pkt_gen_regs_i (.*);

    pkt_gen_sequencer pkt_gen_sequencer_i (.*);

    ip_header_build ip_header_build_i (.*);

    frame_serializer frame_serializer_i (.*);

endmodule

`default_nettype wire

// File: design/frame_serializer.sv
/* Ethernet frame serializer
   Streams Ethernet header, IPv4 header and id payload as AXI-Stream bytes */

`timescale 1ns/1ns
`default_nettype none

module frame_serializer (
    input  wire logic        clk_ifc_avmm,
    input  wire logic        rst_n,
    input  wire logic        hdr_valid,
    input  wire logic [15:0] hdr_checksum,
    input  wire logic [31:0] hdr_id,
    input  wire logic [47:0] dst_mac,
    input  wire logic [7:0]  tos,
    input  wire logic [15:0] identification,
    input  wire logic [7:0]  ttl,
    input  wire logic [7:0]  protocol,
    input  wire logic [31:0] src_ip,
    input  wire logic [31:0] dst_ip,
    input  wire logic        tready,
    output logic             hdr_ready,
    output logic [7:0]       tdata,
    output logic             tvalid,
    output logic             tlast,
    output logic             frame_done,
    output logic             sending
);

    logic [6:0]           byte_cnt;
    logic [15:0]          csum_q;
    logic [31:0]          id_q;
    logic [6:0]           hdr_idx;
    logic [6:0]           pay_off;
    logic                 beat;
    logic [8*(pkt_gen_pkg::eth_hdr_bytes + pkt_gen_pkg::ip_hdr_bytes)-1:0] hdr_bytes;

    assign hdr_ready = !sending;
    assign tvalid    = sending;
    assign tlast     = sending && (byte_cnt == 7'(pkt_gen_pkg::frame_bytes - 1));
    assign beat      = tvalid && tready;

    // Both headers with the first wire byte in the top bits
    assign hdr_bytes = {dst_mac, pkt_gen_pkg::mac_src, pkt_gen_pkg::eth_type_ipv4,
                        pkt_gen_pkg::ip_version_ihl, tos, pkt_gen_pkg::ip_total_length,
                        identification, pkt_gen_pkg::ip_flags_df, 13'b0,
                        ttl, protocol, csum_q, src_ip, dst_ip};

    assign hdr_idx = 7'(pkt_gen_pkg::eth_hdr_bytes + pkt_gen_pkg::ip_hdr_bytes - 1) - byte_cnt;
    assign pay_off = byte_cnt - 7'(pkt_gen_pkg::eth_hdr_bytes + pkt_gen_pkg::ip_hdr_bytes);

    ////////////////////////////////////////////////////////////////////////////
    // Byte select

    always_comb begin
        if (byte_cnt < 7'(pkt_gen_pkg::eth_hdr_bytes + pkt_gen_pkg::ip_hdr_bytes)) begin
            tdata = hdr_bytes[hdr_idx*8 +: 8];
        end else begin
            tdata = id_q[(2'd3 - pay_off[1:0])*8 +: 8];  // Id repeated with MSB first
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Frame walk

    always_ff @(posedge clk_ifc_avmm or negedge rst_n) begin
        if (!rst_n) begin
            sending    <= 1'b0;
            frame_done <= 1'b0;
            byte_cnt   <= '0;
            csum_q     <= '0;
            id_q       <= '0;
        end else begin
            frame_done <= beat && tlast;
            if (hdr_valid && hdr_ready) begin
                sending  <= 1'b1;
                byte_cnt <= '0;
                csum_q   <= hdr_checksum;
                id_q     <= hdr_id;
            end else if (beat) begin
                if (tlast) begin
                    sending <= 1'b0;
                end else begin
                    byte_cnt <= byte_cnt + 7'd1;  // Advance on accepted beat only
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/ip_header_build.sv
/* IPv4 header builder
   Takes a packet request and computes the header checksum in three steps */

`timescale 1ns/1ns
`default_nettype none

module ip_header_build (
    input  wire logic        clk_ifc_avmm,
    input  wire logic        rst_n,
    input  wire logic        req_valid,
    input  wire logic [31:0] req_id,
    input  wire logic [7:0]  tos,
    input  wire logic [15:0] identification,
    input  wire logic [7:0]  ttl,
    input  wire logic [7:0]  protocol,
    input  wire logic [31:0] src_ip,
    input  wire logic [31:0] dst_ip,
    input  wire logic        hdr_ready,
    output logic             req_ready,
    output logic             hdr_valid,
    output logic [15:0]      hdr_checksum,
    output logic [31:0]      hdr_id
);

    logic        sum_vld;
    logic        fold_vld;
    logic [19:0] word_sum;
    logic [19:0] sum_q;
    logic [16:0] fold_q;
    logic [31:0] id_q;

    // Only one header in the pipe at a time
    assign req_ready = !sum_vld && !fold_vld && !hdr_valid;
    assign hdr_id    = id_q;

    // Checksum word itself counts as zero
    assign word_sum = 20'({pkt_gen_pkg::ip_version_ihl, tos})
                    + 20'(pkt_gen_pkg::ip_total_length)
                    + 20'(identification)
                    + 20'({pkt_gen_pkg::ip_flags_df, 13'b0})
                    + 20'({ttl, protocol})
                    + 20'(src_ip[31:16]) + 20'(src_ip[15:0])
                    + 20'(dst_ip[31:16]) + 20'(dst_ip[15:0]);

    always_ff @(posedge clk_ifc_avmm or negedge rst_n) begin
        if (!rst_n) begin
            sum_vld      <= 1'b0;
            fold_vld     <= 1'b0;
            hdr_valid    <= 1'b0;
            sum_q        <= '0;
            fold_q       <= '0;
            id_q         <= '0;
            hdr_checksum <= '0;
        end else begin
            // Step 1, raw sum
            sum_vld <= req_valid && req_ready;
            if (req_valid && req_ready) begin
                sum_q <= word_sum;
                id_q  <= req_id;
            end
            // Step 2, fold carries
            fold_vld <= sum_vld;
            if (sum_vld) begin
                fold_q <= 17'(sum_q[15:0]) + 17'(sum_q[19:16]);
            end
            // Step 3, end-around carry and complement
            if (fold_vld) begin
                hdr_checksum <= ~(fold_q[15:0] + 16'(fold_q[16]));
                hdr_valid    <= 1'b1;
            end else if (hdr_ready) begin
                hdr_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/pkt_gen_sequencer.sv
/* Run control for the packet generator
   Issues packet requests, shapes the rate in continuous mode, counts sent frames */

`timescale 1ns/1ns
`default_nettype none

module pkt_gen_sequencer (
    input  wire logic                   clk_ifc_avmm,
    input  wire logic                   rst_n,
    input  wire logic                   start,
    input  wire logic                   continuous,
    input  wire logic [31:0]            num_packets,
    input  wire pkt_gen_pkg::shaper_dec_t shaper_dec,
    input  wire logic                   req_ready,
    input  wire logic                   frame_done,
    output logic                        req_valid,
    output logic [31:0]                 req_id,
    output pkt_gen_pkg::seq_state_t     state,
    output logic [31:0]                 remaining,
    output pkt_gen_pkg::shaper_accum_t  shaper_accum,
    output logic [63:0]                 tx_cnt
);

    logic        run_cont;   // Continuous flag captured at start
    logic [31:0] pkt_id;     // Id of the last issued packet
    logic [31:0] dec_ext;
    logic        accum_sat;

    assign req_valid  = (state == pkt_gen_pkg::issue);
    assign req_id     = pkt_id + 32'd1;
    assign dec_ext    = {1'b0, shaper_dec};
    // Stop decrementing when negative with top whole bit clear
    assign accum_sat  = shaper_accum.sign && !shaper_accum.whole[14];

    ////////////////////////////////////////////////////////////////////////////
    // Run FSM

    always_ff @(posedge clk_ifc_avmm or negedge rst_n) begin
        if (!rst_n) begin
            state     <= pkt_gen_pkg::idle;
            run_cont  <= 1'b0;
            pkt_id    <= '0;
            remaining <= '0;
            tx_cnt    <= '0;
        end else begin
            case (state)
                pkt_gen_pkg::idle: begin
                    if (start) begin
                        state     <= pkt_gen_pkg::wait_shaper;
                        run_cont  <= continuous;
                        remaining <= num_packets;
                        tx_cnt    <= '0;
                        pkt_id    <= '0;
                    end
                end
                pkt_gen_pkg::wait_shaper: begin
                    // Shaper only applies to continuous runs
                    if (req_ready && (!run_cont || shaper_accum.sign)) begin
                        state <= pkt_gen_pkg::issue;
                    end
                end
                pkt_gen_pkg::issue: begin
                    pkt_id    <= pkt_id + 32'd1;
                    remaining <= run_cont ? 32'd0 : remaining - 32'd1;
                    state     <= pkt_gen_pkg::wait_sent;
                end
                pkt_gen_pkg::wait_sent: begin
                    if (frame_done) begin
                        if (!tx_cnt[63]) begin
                            tx_cnt <= tx_cnt + 64'd1;
                        end
                        if (remaining != 32'd0 || continuous) begin
                            state <= pkt_gen_pkg::wait_shaper;
                        end else begin
                            state <= pkt_gen_pkg::idle;
                        end
                    end
                end
                default: state <= pkt_gen_pkg::idle;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Leaky bucket

    always_ff @(posedge clk_ifc_avmm or negedge rst_n) begin
        if (!rst_n) begin
            shaper_accum <= '0;
        end else if (state == pkt_gen_pkg::idle) begin
            shaper_accum <= '0;
        end else if (state == pkt_gen_pkg::issue) begin
            // Charge one frame length as 15.16 units
            shaper_accum <= shaper_accum + (32'(pkt_gen_pkg::frame_bytes) << 16) - dec_ext;
        end else if (!accum_sat) begin
            shaper_accum <= shaper_accum - dec_ext;
        end
    end

endmodule

`default_nettype wire

// File: design/pkt_gen_regs.sv
/* Packet generator register bank on Avalon-MM
   Holds run and header configuration, returns sequencer status */

`timescale 1ns/1ns
`default_nettype none

module pkt_gen_regs (
    input  wire logic                       clk_ifc_avmm,
    input  wire logic                       rst_n,
    input  wire logic [4:0]                 address,
    input  wire logic                       write,
    input  wire logic [31:0]                writedata,
    input  wire logic                       read,
    output logic [31:0]                     readdata,
    output logic                            start,
    output logic                            continuous,
    output logic [31:0]                     num_packets,
    output pkt_gen_pkg::shaper_dec_t        shaper_dec,
    output logic [7:0]                      tos,
    output logic [15:0]                     identification,
    output logic [7:0]                      ttl,
    output logic [7:0]                      protocol,
    output logic [31:0]                     src_ip,
    output logic [31:0]                     dst_ip,
    output logic [47:0]                     dst_mac,
    input  wire pkt_gen_pkg::seq_state_t    state,
    input  wire logic [31:0]                remaining,
    input  wire pkt_gen_pkg::shaper_accum_t shaper_accum,
    input  wire logic [63:0]                tx_cnt,
    input  wire logic                       sending
);

    logic [31:0] rd_mux;

    ////////////////////////////////////////////////////////////////////////////
    // Write side

    always_ff @(posedge clk_ifc_avmm or negedge rst_n) begin
        if (!rst_n) begin
            start          <= 1'b0;
            continuous     <= 1'b0;
            num_packets    <= '0;
            shaper_dec     <= '0;
            tos            <= '0;
            identification <= '0;
            ttl            <= '0;
            protocol       <= '0;
            src_ip         <= '0;
            dst_ip         <= '0;
            dst_mac        <= '0;
        end else begin
            // Bit 0 of ctrl only fires the pulse
            start <= write && (address == pkt_gen_pkg::addr_ctrl) && writedata[0];
            if (write) begin
                case (address)
                    pkt_gen_pkg::addr_ctrl:           continuous <= writedata[1];
                    pkt_gen_pkg::addr_num_packets:    num_packets <= writedata;
                    pkt_gen_pkg::addr_shaper_dec:     shaper_dec <= writedata[30:0];
                    pkt_gen_pkg::addr_tos:            tos <= writedata[7:0];  // DSCP and ECN
                    pkt_gen_pkg::addr_identification: identification <= writedata[15:0];
                    pkt_gen_pkg::addr_ttl_protocol: begin
                        ttl      <= writedata[15:8];
                        protocol <= writedata[7:0];
                    end
                    pkt_gen_pkg::addr_src_ip:         src_ip <= writedata;
                    pkt_gen_pkg::addr_dst_ip:         dst_ip <= writedata;
                    pkt_gen_pkg::addr_dst_mac_hi:     dst_mac[47:32] <= writedata[15:0];
                    pkt_gen_pkg::addr_dst_mac_lo:     dst_mac[31:0] <= writedata;
                    default: ;
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read side

    always_comb begin
        rd_mux = '0;  // Unmapped reads as zero
        case (address)
            pkt_gen_pkg::addr_ctrl:           rd_mux = {30'b0, continuous, 1'b0};
            pkt_gen_pkg::addr_num_packets:    rd_mux = num_packets;
            pkt_gen_pkg::addr_shaper_dec:     rd_mux = {1'b0, shaper_dec};
            pkt_gen_pkg::addr_tos:            rd_mux = {24'b0, tos};
            pkt_gen_pkg::addr_identification: rd_mux = {16'b0, identification};
            pkt_gen_pkg::addr_ttl_protocol:   rd_mux = {16'b0, ttl, protocol};
            pkt_gen_pkg::addr_src_ip:         rd_mux = src_ip;
            pkt_gen_pkg::addr_dst_ip:         rd_mux = dst_ip;
            pkt_gen_pkg::addr_dst_mac_hi:     rd_mux = {16'b0, dst_mac[47:32]};
            pkt_gen_pkg::addr_dst_mac_lo:     rd_mux = dst_mac[31:0];
            pkt_gen_pkg::addr_status: begin
                rd_mux = {state != pkt_gen_pkg::idle, sending, 22'b0, 6'b0, state};
            end
            pkt_gen_pkg::addr_remaining:      rd_mux = remaining;
            pkt_gen_pkg::addr_shaper_accum:   rd_mux = shaper_accum;
            pkt_gen_pkg::addr_tx_cnt_lo:      rd_mux = tx_cnt[31:0];
            pkt_gen_pkg::addr_tx_cnt_hi:      rd_mux = tx_cnt[63:32];
            default: ;
        endcase
    end

    // Fixed read latency of one cycle
    always_ff @(posedge clk_ifc_avmm or negedge rst_n) begin
        if (!rst_n) begin
            readdata <= '0;
        end else if (read) begin
            readdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

// File: design/pkt_gen_pkg.sv
/* IPv4 packet generator shared definitions
   Frame geometry, fixed header fields, register map, shaper types and FSM states */

`default_nettype none

package pkt_gen_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Frame geometry

    localparam int payload_words = 10;  // 32-bit words of payload
    localparam int eth_hdr_bytes = 14;
    localparam int ip_hdr_bytes  = 20;
    localparam int frame_bytes   = eth_hdr_bytes + ip_hdr_bytes + 4 * payload_words;

    localparam logic [15:0] ip_total_length = 16'(ip_hdr_bytes + 4 * payload_words);

    // Fixed header fields
    localparam logic [47:0] mac_src        = 48'haa_aa_aa_aa_bb_aa;
    localparam logic [15:0] eth_type_ipv4  = 16'h0800;
    localparam logic [2:0]  ip_flags_df    = 3'd2;  // Don't fragment
    localparam logic [7:0]  ip_version_ihl = 8'h45;

    ////////////////////////////////////////////////////////////////////////////
    // Register map, word addresses

    typedef enum logic [4:0] {
        addr_ctrl           = 5'd0,
        addr_num_packets    = 5'd1,
        addr_shaper_dec     = 5'd2,
        addr_tos            = 5'd3,
        addr_identification = 5'd4,
        addr_ttl_protocol   = 5'd5,
        addr_src_ip         = 5'd6,
        addr_dst_ip         = 5'd7,
        addr_dst_mac_hi     = 5'd8,
        addr_dst_mac_lo     = 5'd9,
        addr_status         = 5'd16,  // Read-only from here on
        addr_remaining      = 5'd17,
        addr_shaper_accum   = 5'd18,
        addr_tx_cnt_lo      = 5'd19,
        addr_tx_cnt_hi      = 5'd20
    } reg_addr_t;

    // Shaper fixed point, 15.16
    typedef struct packed {
        logic        sign;
        logic [14:0] whole;
        logic [15:0] fraction;
    } shaper_accum_t;

    typedef struct packed {
        logic [14:0] whole;
        logic [15:0] fraction;
    } shaper_dec_t;

    typedef enum logic [1:0] {
        idle,
        wait_shaper,
        issue,
        wait_sent
    } seq_state_t;

endpackage

`default_nettype wire
